/* hdl/soc_defs.svh */
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// bus widths
`define BUS_AW 32
`define BUS_DW 32
`define MASK_W 4   // one bit per byte lane

// on-chip ram depth in words
`define RAM_WORDS 256

// gpio sizes
`define LED_W 8
`define KEY_W 2

// region codes, compared against addr[31:28]
`define REGION_RAM  4'h0
`define REGION_LED  4'h8
`define REGION_KEYS 4'hC

`endif

/* hdl/bus_pkg.sv */
`default_nettype none

package bus_pkg;

  // single-bit bus operation
  typedef enum logic {
    BUS_READ  = 1'b0,
    BUS_WRITE = 1'b1
  } bus_op_e;

  // decoded target of an access
  typedef enum logic [1:0] {
    RGN_NONE = 2'd0,  // unmapped
    RGN_RAM  = 2'd1,
    RGN_GPIO = 2'd2   // led and keys share one block
  } region_e;

endpackage

`default_nettype wire

/* hdl/periph_pkg.sv */
`default_nettype none

package periph_pkg;

  // register select from addr[3:2]
  typedef enum logic [1:0] {
    GPIO_LED       = 2'd0,  // led region, offset 0
    GPIO_KEY_LEVEL = 2'd1,  // key region, offset 4
    GPIO_KEY_PRESS = 2'd2   // key region, offset 8
  } gpio_reg_e;

endpackage

`default_nettype wire

/* hdl/mmc_router.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module mmc_router (
  input  wire logic                     clk,
  input  wire logic                     i_rst,

  input  wire logic                     i_bus_req,
  input  wire logic                     i_bus_write,
  input  wire logic [`BUS_AW-1:0]       i_bus_addr,
  input  wire logic [`BUS_DW-1:0]       i_bus_data,
  input  wire logic [`MASK_W-1:0]       i_bus_rd_mask,
  input  wire logic [`MASK_W-1:0]       i_bus_wr_mask,
  output logic                          o_bus_ack,
  output logic      [`BUS_DW-1:0]       o_bus_data,

  output logic                          o_ram_req,
  output logic                          o_gpio_req,
  output bus_pkg::bus_op_e              o_tgt_op,
  output logic      [`BUS_AW-1:0]       o_tgt_addr,
  output logic      [`BUS_DW-1:0]       o_tgt_data,
  output logic      [`MASK_W-1:0]       o_tgt_wr_mask,
  input  wire logic                     i_ram_ack,
  input  wire logic [`BUS_DW-1:0]       i_ram_data,
  input  wire logic                     i_gpio_ack,
  input  wire logic [`BUS_DW-1:0]       i_gpio_data
);

  import bus_pkg::*;

  region_e            region_d;
  region_e            region_q;   // target of the access in flight
  logic               req_q;
  logic [`MASK_W-1:0] rd_mask_q;
  logic [`BUS_DW-1:0] tgt_word;
  logic [`BUS_DW-1:0] mask_bits;

  always_comb
  begin
    case (i_bus_addr[`BUS_AW-1 -: 4])
      `REGION_RAM:  region_d = RGN_RAM;
      `REGION_LED:  region_d = RGN_GPIO;
      `REGION_KEYS: region_d = RGN_GPIO;
      default:      region_d = RGN_NONE;
    endcase
  end

  // dispatch, no added delay
  assign o_ram_req     = i_bus_req && (region_d == RGN_RAM);
  assign o_gpio_req    = i_bus_req && (region_d == RGN_GPIO);
  assign o_tgt_op      = i_bus_write ? BUS_WRITE : BUS_READ;
  assign o_tgt_addr    = i_bus_addr;
  assign o_tgt_data    = i_bus_data;
  assign o_tgt_wr_mask = i_bus_wr_mask;

  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      req_q    <= 1'b0;
      region_q <= RGN_NONE;
    end
    else
    begin
      req_q <= i_bus_req;
      if (i_bus_req)
        region_q <= region_d;
    end
  end

  // writes return zero, so their mask is dropped here
  always_ff @(posedge clk)
  begin
    if (i_bus_req)
      rd_mask_q <= i_bus_write ? '0 : i_bus_rd_mask;
  end

  always_comb
  begin
    case (region_q)
      RGN_RAM:  tgt_word = i_ram_data;
      RGN_GPIO: tgt_word = i_gpio_data;
      default:  tgt_word = '0;
    endcase
  end

  always_comb
  begin
    for (int b = 0; b < `MASK_W; b++)
    begin
      mask_bits[8*b +: 8] = {8{rd_mask_q[b]}};
    end
  end

  assign o_bus_ack = ((region_q == RGN_RAM)  && i_ram_ack)  ||
                     ((region_q == RGN_GPIO) && i_gpio_ack) ||
                     ((region_q == RGN_NONE) && req_q);  // unmapped, answered here

  assign o_bus_data = o_bus_ack ? (tgt_word & mask_bits) : '0;

endmodule

`default_nettype wire

/* hdl/ram_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module ram_bank (
  input  wire logic                 clk,
  input  wire logic                 i_rst,

  input  wire logic                 i_req,
  input  wire bus_pkg::bus_op_e     i_op,
  input  wire logic [`BUS_AW-1:0]   i_addr,
  input  wire logic [`BUS_DW-1:0]   i_data,
  input  wire logic [`MASK_W-1:0]   i_wr_mask,
  output logic                      o_ack,
  output logic      [`BUS_DW-1:0]   o_data
);

  import bus_pkg::*;

  localparam int IDX_W = $clog2(`RAM_WORDS);

  logic [`BUS_DW-1:0] mem [`RAM_WORDS];
  logic [IDX_W-1:0]   idx;

  assign idx = i_addr[IDX_W+1:2];  // word index, byte offset dropped

  // byte-enable write
  always_ff @(posedge clk)
  begin
    if (i_req && (i_op == BUS_WRITE))
    begin
      for (int b = 0; b < `MASK_W; b++)
      begin
        if (i_wr_mask[b])
          mem[idx][8*b +: 8] <= i_data[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_req)
      o_data <= mem[idx];  // old word on a write
  end

  always_ff @(posedge clk)
  begin
    if (i_rst)
      o_ack <= 1'b0;
    else
      o_ack <= i_req;
  end

endmodule

`default_nettype wire

/* hdl/gpio_block.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module gpio_block (
  input  wire logic                 clk,
  input  wire logic                 i_rst,

  input  wire logic                 i_req,
  input  wire bus_pkg::bus_op_e     i_op,
  input  wire logic [`BUS_AW-1:0]   i_addr,
  input  wire logic [`BUS_DW-1:0]   i_data,
  input  wire logic [`MASK_W-1:0]   i_wr_mask,
  output logic                      o_ack,
  output logic      [`BUS_DW-1:0]   o_data,

  input  wire logic [`KEY_W-1:0]    i_keys,  // active low
  output logic      [`LED_W-1:0]    o_led
);

  import bus_pkg::*;
  import periph_pkg::*;

  gpio_reg_e          reg_sel;
  logic               wr_en;
  logic [`LED_W-1:0]  led_q;
  logic [`KEY_W-1:0]  key_meta;
  logic [`KEY_W-1:0]  key_sync;
  logic [`KEY_W-1:0]  key_level;
  logic [`KEY_W-1:0]  key_press;
  logic [`KEY_W-1:0]  press_set;
  logic [`KEY_W-1:0]  press_clr;

  assign reg_sel = gpio_reg_e'(i_addr[3:2]);
  assign wr_en   = i_req && (i_op == BUS_WRITE);

  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      led_q <= '0;
    end
    else if (wr_en && (reg_sel == GPIO_LED))
    begin
      for (int i = 0; i < `LED_W; i++)
      begin
        if (i_wr_mask[i/8])
          led_q[i] <= i_data[i];
      end
    end
  end

  assign o_led = led_q;

  // two-flop synchronizer, idle keys read high
  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      key_meta  <= '1;
      key_sync  <= '1;
      key_level <= '1;
    end
    else
    begin
      key_meta  <= i_keys;
      key_sync  <= key_meta;
      key_level <= key_sync;
    end
  end

  // falling edge of the synced key is a press
  assign press_set = key_level & ~key_sync;
  assign press_clr = (wr_en && (reg_sel == GPIO_KEY_PRESS) && i_wr_mask[0]) ?
                     i_data[`KEY_W-1:0] : '0;

  always_ff @(posedge clk)
  begin
    if (i_rst)
      key_press <= '0;
    else
      key_press <= (key_press | press_set) & ~press_clr;  // clear wins
  end

  always_ff @(posedge clk)
  begin
    if (i_req)
    begin
      case (reg_sel)
        GPIO_LED:       o_data <= {{(`BUS_DW-`LED_W){1'b0}}, led_q};
        GPIO_KEY_LEVEL: o_data <= {{(`BUS_DW-`KEY_W){1'b0}}, key_level};
        GPIO_KEY_PRESS: o_data <= {{(`BUS_DW-`KEY_W){1'b0}}, key_press};
        default:        o_data <= '0;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_rst)
      o_ack <= 1'b0;
    else
      o_ack <= i_req;
  end

endmodule

`default_nettype wire

/* hdl/soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module soc_top (
  input  wire logic                 clk,
  input  wire logic                 i_rst,

  input  wire logic                 i_bus_req,
  input  wire logic                 i_bus_write,
  input  wire logic [`BUS_AW-1:0]   i_bus_addr,
  input  wire logic [`BUS_DW-1:0]   i_bus_data,
  input  wire logic [`MASK_W-1:0]   i_bus_rd_mask,
  input  wire logic [`MASK_W-1:0]   i_bus_wr_mask,
  output logic                      o_bus_ack,
  output logic      [`BUS_DW-1:0]   o_bus_data,

  input  wire logic [`KEY_W-1:0]    i_keys,
  output logic      [`LED_W-1:0]    o_led
);

  import bus_pkg::*;

  logic               ram_req;
  logic               gpio_req;
  bus_op_e            tgt_op;
  logic [`BUS_AW-1:0] tgt_addr;
  logic [`BUS_DW-1:0] tgt_data;
  logic [`MASK_W-1:0] tgt_wr_mask;
  logic               ram_ack;
  logic [`BUS_DW-1:0] ram_data;
  logic               gpio_ack;
  logic [`BUS_DW-1:0] gpio_data;

  mmc_router u_router (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_bus_req     (i_bus_req),
    .i_bus_write   (i_bus_write),
    .i_bus_addr    (i_bus_addr),
    .i_bus_data    (i_bus_data),
    .i_bus_rd_mask (i_bus_rd_mask),
    .i_bus_wr_mask (i_bus_wr_mask),
    .o_bus_ack     (o_bus_ack),
    .o_bus_data    (o_bus_data),
    .o_ram_req     (ram_req),
    .o_gpio_req    (gpio_req),
    .o_tgt_op      (tgt_op),
    .o_tgt_addr    (tgt_addr),
    .o_tgt_data    (tgt_data),
    .o_tgt_wr_mask (tgt_wr_mask),
    .i_ram_ack     (ram_ack),
    .i_ram_data    (ram_data),
    .i_gpio_ack    (gpio_ack),
    .i_gpio_data   (gpio_data)
  );

  ram_bank u_ram (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_req     (ram_req),
    .i_op      (tgt_op),
    .i_addr    (tgt_addr),
    .i_data    (tgt_data),
    .i_wr_mask (tgt_wr_mask),
    .o_ack     (ram_ack),
    .o_data    (ram_data)
  );

  gpio_block u_gpio (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_req     (gpio_req),
    .i_op      (tgt_op),
    .i_addr    (tgt_addr),
    .i_data    (tgt_data),
    .i_wr_mask (tgt_wr_mask),
    .o_ack     (gpio_ack),
    .o_data    (gpio_data),
    .i_keys    (i_keys),
    .o_led     (o_led)
  );

endmodule

`default_nettype wire

/* sim/tb_soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module tb_soc_top;

  import periph_pkg::*;

  localparam int CLK_NS      = 10;
  localparam int RAM_SET     = 16;
  localparam int RAM_MASKED  = 32;
  localparam int MASK_READS  = 16;
  localparam int LED_WRITES  = 8;
  localparam int SETTLE      = 5;  // synchronizer depth plus margin
  localparam int ACCESSES    = 20 + 3*RAM_SET + RAM_MASKED + 2*MASK_READS + 2*LED_WRITES;
  localparam int WATCHDOG_NS = (4 + 3*ACCESSES + 5*SETTLE) * CLK_NS * 2;

  logic               clk = 1'b0;
  logic               rst;
  logic               bus_req;
  logic               bus_write;
  logic [`BUS_AW-1:0] bus_addr;
  logic [`BUS_DW-1:0] bus_data;
  logic [`MASK_W-1:0] rd_mask;
  logic [`MASK_W-1:0] wr_mask;
  logic               bus_ack;
  logic [`BUS_DW-1:0] bus_rdata;
  logic [`KEY_W-1:0]  keys;
  logic [`LED_W-1:0]  led;

  logic [15:0]        lfsr;
  logic [`BUS_DW-1:0] ram_model [`RAM_WORDS];
  logic [7:0]         used_idx [RAM_SET];  // words already fully written
  logic [`LED_W-1:0]  led_model;
  logic [`KEY_W-1:0]  press_model;
  int                 checks;
  int                 errors;
  int                 test_start;

  soc_top i_soc_top (
    .clk           (clk),
    .i_rst         (rst),
    .i_bus_req     (bus_req),
    .i_bus_write   (bus_write),
    .i_bus_addr    (bus_addr),
    .i_bus_data    (bus_data),
    .i_bus_rd_mask (rd_mask),
    .i_bus_wr_mask (wr_mask),
    .o_bus_ack     (bus_ack),
    .o_bus_data    (bus_rdata),
    .i_keys        (keys),
    .o_led         (led)
  );

  always #(CLK_NS/2) clk = ~clk;

  assert property (@(posedge clk) disable iff (rst) bus_req |=> bus_ack)
  else
  begin
    errors++;
    $display("Error at %0t ns: no acknowledge one cycle after a request", $time);
  end

  assert property (@(posedge clk) disable iff (rst) bus_ack |-> $past(bus_req))
  else
  begin
    errors++;
    $display("Error at %0t ns: acknowledge without a request", $time);
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  function automatic logic [31:0] ram_addr(input logic [7:0] idx);
    return {`REGION_RAM, 18'h0, idx, 2'b00};
  endfunction

  function automatic logic [31:0] gpio_addr(input gpio_reg_e r);
    return {(r == GPIO_LED) ? `REGION_LED : `REGION_KEYS, 24'h0, r, 2'b00};
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("Error at %0t ns: %s returned %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic access(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                        input logic [3:0] rmask, input logic [3:0] wmask,
                        output logic [31:0] rdata);
    int waited;
    @(posedge clk);
    #1;
    bus_req   = 1'b1;
    bus_write = wr;
    bus_addr  = addr;
    bus_data  = data;
    rd_mask   = rmask;
    wr_mask   = wmask;
    @(posedge clk);
    #1;
    bus_req = 1'b0;
    waited  = 0;
    while (!bus_ack && waited < 8)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    rdata = bus_rdata;
    if (!bus_ack)
    begin
      errors++;
      $display("access to %h got no acknowledge within 8 cycles", addr);
    end
    else if (wr)
      check("write", rdata, '0);  // writes answer with zero
  endtask

  task automatic read_check(input string what, input logic [31:0] addr,
                            input logic [3:0] rmask, input logic [31:0] exp);
    logic [31:0] got;
    access(1'b0, addr, '0, rmask, '0, got);
    check(what, got, exp & lane_mask(rmask));
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] wmask);
    logic [31:0] got;
    access(1'b1, addr, data, 4'hF, wmask, got);  // full read mask, data must still be zero
  endtask

  task automatic set_keys(input logic [1:0] k);
    @(posedge clk);
    #1;
    press_model = press_model | (keys & ~k);  // high to low is a press
    keys        = k;
    repeat (SETTLE) @(posedge clk);
  endtask

  task automatic keys_check();
    read_check("key level", gpio_addr(GPIO_KEY_LEVEL), 4'hF, {30'h0, keys});
    read_check("key press", gpio_addr(GPIO_KEY_PRESS), 4'hF, {30'h0, press_model});
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %s, %0d errors", num, name,
             (errors == test_start) ? "ok" : "failed", errors - test_start);
    test_start = errors;
  endtask

  initial
  begin
    logic [7:0]  idx;
    logic [31:0] data;
    logic [3:0]  m;
    lfsr        = 16'd86;
    checks      = 0;
    errors      = 0;
    test_start  = 0;
    rst         = 1'b1;
    bus_req     = 1'b0;
    bus_write   = 1'b0;
    bus_addr    = '0;
    bus_data    = '0;
    rd_mask     = '0;
    wr_mask     = '0;
    keys        = '1;  // keys idle high
    led_model   = '0;
    press_model = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    check("o_led after reset", {24'h0, led}, '0);
    check("o_bus_ack after reset", {31'h0, bus_ack}, '0);
    read_check("led register", gpio_addr(GPIO_LED), 4'hF, '0);
    read_check("key press", gpio_addr(GPIO_KEY_PRESS), 4'hF, '0);
    end_test(1, "reset state");

    for (int i = 0; i < RAM_SET; i++)
    begin
      used_idx[i]            = 8'(rand_bits(8));
      data                   = rand_bits(32);
      ram_model[used_idx[i]] = data;
      write_word(ram_addr(used_idx[i]), data, 4'hF);
    end
    for (int i = 0; i < RAM_MASKED; i++)
    begin
      idx            = used_idx[rand_bits(4)];
      data           = rand_bits(32);
      m              = 4'(rand_bits(4));
      ram_model[idx] = (ram_model[idx] & ~lane_mask(m)) | (data & lane_mask(m));
      write_word(ram_addr(idx), data, m);
    end
    for (int i = 0; i < RAM_SET; i++)
      read_check("ram word", ram_addr(used_idx[i]), 4'hF, ram_model[used_idx[i]]);
    end_test(2, "ram byte writes");

    for (int i = 0; i < MASK_READS; i++)
    begin
      idx = used_idx[rand_bits(4)];
      m   = 4'(rand_bits(4));
      read_check("ram masked read", ram_addr(idx), m, ram_model[idx]);
      m   = 4'(rand_bits(4));
      read_check("gpio masked read", gpio_addr(GPIO_KEY_LEVEL), m, {30'h0, keys});
    end
    end_test(3, "read masks");

    for (int i = 0; i < LED_WRITES; i++)
    begin
      data = rand_bits(32);
      m    = 4'(rand_bits(4));
      if (m[0])
        led_model = data[7:0];  // only lane 0 holds leds
      write_word(gpio_addr(GPIO_LED), data, m);
      check("o_led", {24'h0, led}, {24'h0, led_model});
      read_check("led register", gpio_addr(GPIO_LED), 4'hF, {24'h0, led_model});
    end
    end_test(4, "led writes");

    set_keys(2'b10);
    keys_check();
    set_keys(2'b11);
    keys_check();
    set_keys(2'b01);
    keys_check();
    set_keys(2'b11);
    keys_check();
    write_word(gpio_addr(GPIO_KEY_PRESS), 32'h1, 4'h1);
    press_model[0] = 1'b0;
    keys_check();
    write_word(gpio_addr(GPIO_KEY_PRESS), 32'h2, 4'h1);
    press_model[1] = 1'b0;
    keys_check();
    end_test(5, "keys");

    data = rand_bits(32);
    write_word({4'h4, 18'h0, used_idx[0], 2'b00}, data, 4'hF);  // aliases a ram word
    write_word(32'hF000_0000, data, 4'hF);                      // aliases the led offset
    read_check("unmapped read", {4'h4, 18'h0, used_idx[0], 2'b00}, 4'hF, '0);
    read_check("unmapped read", 32'hF000_0000, 4'hF, '0);
    check("o_led", {24'h0, led}, {24'h0, led_model});
    for (int i = 0; i < RAM_SET; i++)
      read_check("ram word", ram_addr(used_idx[i]), 4'hF, ram_model[used_idx[i]]);
    end_test(6, "unmapped region");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hdl
hdl/bus_pkg.sv
hdl/periph_pkg.sv
hdl/mmc_router.sv
hdl/ram_bank.sv
hdl/gpio_block.sv
hdl/soc_top.sv
sim/tb_soc_top.sv

/* Bender.yml */
package:
  name: soc_mmio

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/bus_pkg.sv
      - hdl/periph_pkg.sv
      - hdl/mmc_router.sv
      - hdl/ram_bank.sv
      - hdl/gpio_block.sv
      - hdl/soc_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - sim/tb_soc_top.sv
